// File: logic/lsqPkg.sv
package lsqPkg;

  // bundle and retire word geometry
  localparam int SlotCount = 6;
  localparam int InstCount = 10;
  localparam int LineBits = 14;
  localparam int BankCount = 32;
  localparam int HalfBanks = BankCount / 2;
  localparam int BundleIdBits = 6;
  localparam int IdxBits = 4;
  localparam int ExcBits = 4;

  // one access, even and odd line plus touched banks
  typedef struct packed {
    logic [LineBits-1:0] addrE;
    logic [LineBits-1:0] addrO;
    logic evenLow;
    logic evenHigh;
    logic oddLow;
    logic oddHigh;
    logic [BankCount-1:0] banks;
  } lsAddr;

  typedef struct packed {
    logic valid;
    logic [IdxBits-1:0] instIdx;
    logic excpt;
    logic [ExcBits-1:0] exBits;
    lsAddr addr;
  } lsSlot;

  typedef struct packed {
    logic [BundleIdBits-1:0] bundleId;
    lsSlot [SlotCount-1:0] slots;
  } lsBundle;

  // confl rows are later slots, columns earlier slots
  typedef struct packed {
    lsBundle bundle;
    logic [SlotCount-1:0] ldConfl;
    logic [SlotCount-1:0][SlotCount-1:0] confl;
  } lsChecked;

  // indexed by instruction number, not by slot
  typedef struct packed {
    logic [BundleIdBits-1:0] bundleId;
    logic [InstCount-1:0] enMask;
    logic [InstCount-1:0] fine;
    logic [InstCount-1:0] ldConfl;
    logic [InstCount-1:0] except;
    logic [InstCount-1:0][ExcBits-1:0] exBits;
  } lsRetire;

endpackage

// File: logic/lsqConflictPair.sv
`timescale 1ns/1ps

module lsqConflictPair import lsqPkg::*; (
  input  lsAddr a,
  input  lsAddr b,
  output logic  confl
);

  logic matchE;
  logic matchO;
  logic bankLow;
  logic bankHigh;
  logic hitOddHigh;
  logic hitOddLow;
  logic hitEvenHigh;
  logic hitEvenLow;

  // same line index on each half
  assign matchE = (a.addrE == b.addrE);
  assign matchO = (a.addrO == b.addrO);

  // any shared bank in the low or high half
  assign bankLow = |(a.banks[HalfBanks-1:0] & b.banks[HalfBanks-1:0]);
  assign bankHigh = |(a.banks[BankCount-1:HalfBanks] & b.banks[BankCount-1:HalfBanks]);

  assign hitOddHigh = a.oddHigh && b.oddHigh && matchO && bankHigh;
  assign hitOddLow = a.oddLow && b.oddLow && matchO && bankLow;
  assign hitEvenHigh = a.evenHigh && b.evenHigh && matchE && bankHigh;
  assign hitEvenLow = a.evenLow && b.evenLow && matchE && bankLow;

  assign confl = hitOddHigh || hitOddLow || hitEvenHigh || hitEvenLow;

endmodule

// File: logic/lsqBundleCheck.sv
`timescale 1ns/1ps

module lsqBundleCheck import lsqPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  logic     take,
  input  lsBundle  bundle,
  output logic     checkValid,
  output lsChecked checked
);

  logic [SlotCount-1:0][SlotCount-1:0] pairRaw;
  logic [SlotCount-1:0][SlotCount-1:0] conflNext;
  logic [SlotCount-1:0] ldNext;

  // one pair check per later/earlier slot combination
  for (genvar later = 0; later < SlotCount; later++) begin : g_later
    for (genvar earlier = 0; earlier < SlotCount; earlier++) begin : g_earlier
      if (earlier < later) begin : g_pair
        lsqConflictPair i_pair (
          .a     (bundle.slots[later].addr),
          .b     (bundle.slots[earlier].addr),
          .confl (pairRaw[later][earlier])
        );
      end else begin : g_none
        assign pairRaw[later][earlier] = 1'b0;
      end
    end
  end

  // only valid against valid counts
  always_comb begin
    for (int later = 0; later < SlotCount; later++) begin
      for (int earlier = 0; earlier < SlotCount; earlier++) begin
        conflNext[later][earlier] = pairRaw[later][earlier]
                                  && bundle.slots[later].valid
                                  && bundle.slots[earlier].valid;
      end
      ldNext[later] = |conflNext[later];
    end
  end

  // a transfer in the flush cycle is dropped here
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      checkValid <= 1'b0;
    end else begin
      checkValid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      checked.bundle <= bundle;
      checked.ldConfl <= ldNext;
      checked.confl <= conflNext;
    end
  end

endmodule

// File: logic/lsqBundleBuffer.sv
`timescale 1ns/1ps

module lsqBundleBuffer import lsqPkg::*; #(
  parameter int Depth = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush,
  input  logic                         push,
  input  lsChecked                     pushData,
  output logic                         headValid,
  output lsChecked                     head,
  input  logic                         headPop,
  output logic [$clog2(Depth+1)-1:0]   count
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountBits = $clog2(Depth + 1);

  lsChecked mem [Depth];
  logic [PtrBits-1:0] wrPtr;
  logic [PtrBits-1:0] rdPtr;
  logic doPush;
  logic doPop;

  // wrap explicitly so non power of two depths also work
  function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
    logic [PtrBits-1:0] result;
    if (ptr == PtrBits'(Depth - 1)) begin
      result = '0;
    end else begin
      result = ptr + PtrBits'(1);
    end
    return result;
  endfunction

  assign headValid = (count != '0);
  assign head = mem[rdPtr];

  // top only pushes when there is room
  assign doPush = push && !flush;
  assign doPop = headPop && headValid && !flush;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doPush, doPop})
        2'b10: count <= count + CountBits'(1);
        2'b01: count <= count - CountBits'(1);
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

endmodule

// File: logic/lsqRetireDecide.sv
`timescale 1ns/1ps

module lsqRetireDecide import lsqPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  logic     headValid,
  input  lsChecked head,
  output logic     headPop,
  output logic     outValid,
  input  logic     outReady,
  output lsRetire  retire
);

  logic [InstCount-1:0][SlotCount-1:0] hitMap;
  lsRetire word;

  // take the head when the output slot is free or being drained
  assign headPop = headValid && (!outValid || outReady);

  // which valid slots carry each instruction index
  always_comb begin
    for (int i = 0; i < InstCount; i++) begin
      for (int s = 0; s < SlotCount; s++) begin
        hitMap[i][s] = head.bundle.slots[s].valid
                     && (head.bundle.slots[s].instIdx == IdxBits'(i));
      end
    end
  end

  // fold slot flags onto instruction indices
  always_comb begin
    word = '0;
    word.bundleId = head.bundle.bundleId;
    for (int i = 0; i < InstCount; i++) begin
      for (int s = 0; s < SlotCount; s++) begin
        word.enMask[i] = word.enMask[i] | hitMap[i][s];
        word.except[i] = word.except[i] | (hitMap[i][s] & head.bundle.slots[s].excpt);
        word.ldConfl[i] = word.ldConfl[i] | (hitMap[i][s] & head.ldConfl[s]);
        word.exBits[i] = word.exBits[i]
                       | ({ExcBits{hitMap[i][s]}} & head.bundle.slots[s].exBits);
      end
      // clean retire only when nothing went wrong
      word.fine[i] = word.enMask[i] && !word.except[i] && !word.ldConfl[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      outValid <= 1'b0;
    end else if (headPop) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;
    end
  end

  // word holds until the next pop, so it is stable under back-pressure
  always_ff @(posedge clk) begin
    if (headPop && !flush) begin
      retire <= word;
    end
  end

endmodule

// File: logic/lsqTop.sv
`timescale 1ns/1ps

module lsqTop import lsqPkg::*; #(
  parameter int Depth = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    inValid,
  output logic    inReady,
  input  lsBundle inBundle,
  output logic    outValid,
  input  logic    outReady,
  output lsRetire retire
);

  localparam int CountBits = $clog2(Depth + 1);

  logic take;
  logic checkValid;
  lsChecked checked;
  logic headValid;
  lsChecked head;
  logic headPop;
  logic [CountBits-1:0] count;
  logic [CountBits:0] occupancy;

  // check stage counts as one more buffer entry
  assign occupancy = (CountBits+1)'(count) + (CountBits+1)'(checkValid);
  assign inReady = (occupancy < (CountBits+1)'(Depth));
  assign take = inValid && inReady;

  lsqBundleCheck i_check (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .take       (take),
    .bundle     (inBundle),
    .checkValid (checkValid),
    .checked    (checked)
  );

  lsqBundleBuffer #(
    .Depth (Depth)
  ) i_buffer (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .push      (checkValid),
    .pushData  (checked),
    .headValid (headValid),
    .head      (head),
    .headPop   (headPop),
    .count     (count)
  );

  lsqRetireDecide i_retire (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .headValid (headValid),
    .head      (head),
    .headPop   (headPop),
    .outValid  (outValid),
    .outReady  (outReady),
    .retire    (retire)
  );

endmodule

// File: sim/lsqTop_properties.sv
`timescale 1ns/1ps

module lsqTopProperties import lsqPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    flush,
  input logic    outValid,
  input logic    outReady,
  input lsRetire retire
);

  // failed assertions so far
  int failCount = 0;

  // nothing offered right out of reset
  property quietAfterReset;
    @(posedge clk) rst |=> !outValid;
  endproperty

  // word held while the consumer stalls
  property holdUnderStall;
    @(posedge clk) disable iff (rst)
      (outValid && !outReady && !flush) |=> (outValid && $stable(retire));
  endproperty

  property emptyAfterFlush;
    @(posedge clk) flush |=> !outValid;
  endproperty

  assert property (quietAfterReset) else begin
    $error("outValid high after reset");
    failCount++;
  end

  assert property (holdUnderStall) else begin
    $error("retire word changed under back-pressure");
    failCount++;
  end

  assert property (emptyAfterFlush) else begin
    $error("outValid high after flush");
    failCount++;
  end

endmodule

bind lsqTop lsqTopProperties i_props (
  .clk      (clk),
  .rst      (rst),
  .flush    (flush),
  .outValid (outValid),
  .outReady (outReady),
  .retire   (retire)
);

// File: sim/lsqTb.sv
`timescale 1ns/1ps

module lsqTb import lsqPkg::*; ();

  localparam int Depth = 4;
  // crafted, mapping, stream, back-pressure and flush bundles
  localparam int SentBundles = 2 + 7 + 40 + (Depth + 1) + 5;
  localparam int CycleLimit = SentBundles * 10 + 200;

  logic clk = 1'b0;
  logic rst;
  logic flush;
  logic inValid;
  logic inReady;
  lsBundle inBundle;
  logic outValid;
  logic outReady;
  lsRetire retire;

  integer seed = 92;
  int cycles = 0;
  int nextId = 0;
  int lastSendCycle = 0;
  int lastOutCycle = 0;
  lsRetire expQ[$];
  lsRetire expWord;

  lsqTop #(
    .Depth (Depth)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .inValid  (inValid),
    .inReady  (inReady),
    .inBundle (inBundle),
    .outValid (outValid),
    .outReady (outReady),
    .retire   (retire)
  );

  always #5 clk = ~clk;

  task automatic stopRun(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expVal,
                       input logic [63:0] actVal);
    if (expVal !== actVal) begin
      $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // reference for the bank conflict rule
  function automatic logic pairConflict(input lsAddr a, input lsAddr b);
    logic lowShare;
    logic highShare;
    logic oddHit;
    logic evenHit;
    lowShare = |(a.banks[15:0] & b.banks[15:0]);
    highShare = |(a.banks[31:16] & b.banks[31:16]);
    oddHit = (a.addrO == b.addrO)
           && ((a.oddHigh && b.oddHigh && highShare) || (a.oddLow && b.oddLow && lowShare));
    evenHit = (a.addrE == b.addrE)
            && ((a.evenHigh && b.evenHigh && highShare) || (a.evenLow && b.evenLow && lowShare));
    return oddHit || evenHit;
  endfunction

  function automatic logic [SlotCount-1:0] slotFlags(input lsBundle b);
    logic [SlotCount-1:0] f;
    f = '0;
    for (int later = 1; later < SlotCount; later++) begin
      for (int earlier = 0; earlier < later; earlier++) begin
        if (b.slots[later].valid && b.slots[earlier].valid
            && pairConflict(b.slots[later].addr, b.slots[earlier].addr)) begin
          f[later] = 1'b1;
        end
      end
    end
    return f;
  endfunction

  function automatic lsRetire expectRetire(input lsBundle b);
    lsRetire r;
    logic [SlotCount-1:0] f;
    int idx;
    r = '0;
    r.bundleId = b.bundleId;
    f = slotFlags(b);
    for (int s = 0; s < SlotCount; s++) begin
      if (b.slots[s].valid) begin
        idx = int'(b.slots[s].instIdx);
        r.enMask[idx] = 1'b1;
        r.except[idx] = r.except[idx] | b.slots[s].excpt;
        r.ldConfl[idx] = r.ldConfl[idx] | f[s];
        r.exBits[idx] = r.exBits[idx] | b.slots[s].exBits;
      end
    end
    r.fine = r.enMask & ~r.except & ~r.ldConfl;
    return r;
  endfunction

  // flags are {evenLow, evenHigh, oddLow, oddHigh}
  function automatic lsAddr mkAddr(input int e, input int o, input logic [3:0] flags,
                                   input logic [31:0] banks);
    lsAddr a;
    a.addrE = LineBits'(e);
    a.addrO = LineBits'(o);
    {a.evenLow, a.evenHigh, a.oddLow, a.oddHigh} = flags;
    a.banks = banks;
    return a;
  endfunction

  function automatic lsSlot mkSlot(input int idx, input logic ex, input logic [3:0] bits,
                                   input lsAddr addr);
    lsSlot s;
    s.valid = 1'b1;
    s.instIdx = IdxBits'(idx);
    s.excpt = ex;
    s.exBits = bits;
    s.addr = addr;
    return s;
  endfunction

  // small line range so random slots do collide
  function automatic lsBundle randBundle();
    lsBundle b;
    b = '0;
    for (int s = 0; s < SlotCount; s++) begin
      b.slots[s].valid = (($random(seed) % 4) != 0);
      b.slots[s].instIdx = IdxBits'($unsigned($random(seed)) % InstCount);
      b.slots[s].excpt = (($random(seed) % 8) == 0);
      b.slots[s].exBits = ExcBits'($random(seed));
      b.slots[s].addr = mkAddr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 4,
                               4'($random(seed)), $random(seed) & $random(seed));
    end
    return b;
  endfunction

  // called at a falling edge, returns at a falling edge
  task automatic sendBundle(input lsBundle b);
    b.bundleId = BundleIdBits'(nextId);
    nextId++;
    inBundle = b;
    inValid = 1'b1;
    while (!inReady) begin
      @(negedge clk);
    end
    expQ.push_back(expectRetire(b));
    @(posedge clk);
    lastSendCycle = cycles;
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic drainOutputs(input string what);
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < 60) begin
      @(negedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      stopRun({what, ": expected retire words never arrived"});
    end
  endtask

  task automatic compareWord(input lsRetire e, input lsRetire a);
    check("retire.bundleId", e.bundleId, a.bundleId);
    check("retire.enMask", e.enMask, a.enMask);
    check("retire.fine", e.fine, a.fine);
    check("retire.ldConfl", e.ldConfl, a.ldConfl);
    check("retire.except", e.except, a.except);
    check("retire.exBits", e.exBits, a.exBits);
  endtask

  task automatic testLatencyConflict();
    lsBundle b;
    int sentCycle;
    b = '0;
    // odd half pairs, a disjoint bank half and a different line
    b.slots[0] = mkSlot(0, 1'b0, 4'h0, mkAddr(0, 5, 4'b0001, 32'h0010_0000));
    b.slots[1] = mkSlot(1, 1'b0, 4'h0, mkAddr(0, 5, 4'b0001, 32'h0010_0000));
    b.slots[2] = mkSlot(2, 1'b0, 4'h0, mkAddr(0, 7, 4'b0010, 32'h0000_0008));
    b.slots[3] = mkSlot(3, 1'b0, 4'h0, mkAddr(0, 7, 4'b0010, 32'h0000_0008));
    b.slots[4] = mkSlot(4, 1'b0, 4'h0, mkAddr(0, 5, 4'b0011, 32'h0000_0010));
    b.slots[5] = mkSlot(5, 1'b0, 4'h0, mkAddr(0, 6, 4'b0001, 32'h0010_0000));
    check("model flags odd", 6'b001010, slotFlags(b));
    outReady = 1'b1;
    sendBundle(b);
    sentCycle = lastSendCycle;
    drainOutputs("latency");
    check("latency cycles", 3, lastOutCycle - sentCycle);
    // same pattern on the even half
    b.slots[0] = mkSlot(0, 1'b0, 4'h0, mkAddr(9, 0, 4'b0100, 32'h8000_0000));
    b.slots[1] = mkSlot(1, 1'b0, 4'h0, mkAddr(9, 0, 4'b0100, 32'h8000_0000));
    b.slots[2] = mkSlot(2, 1'b0, 4'h0, mkAddr(2, 0, 4'b1000, 32'h0000_0001));
    b.slots[3] = mkSlot(3, 1'b0, 4'h0, mkAddr(2, 0, 4'b1000, 32'h0000_0001));
    b.slots[4] = mkSlot(4, 1'b0, 4'h0, mkAddr(9, 0, 4'b1100, 32'h0000_0001));
    b.slots[5] = mkSlot(5, 1'b0, 4'h0, mkAddr(3, 0, 4'b1000, 32'h0000_0001));
    check("model flags even", 6'b001010, slotFlags(b));
    sendBundle(b);
    drainOutputs("even conflicts");
  endtask

  task automatic testMapping();
    lsBundle b;
    lsRetire r;
    b = '0;
    b.slots[0] = mkSlot(3, 1'b0, 4'h1, mkAddr(1, 0, 4'b1000, 32'h1));
    b.slots[1] = mkSlot(3, 1'b1, 4'h4, mkAddr(2, 0, 4'b1000, 32'h1));
    b.slots[2] = mkSlot(7, 1'b1, 4'hf, mkAddr(6, 0, 4'b1000, 32'h1));
    b.slots[2].valid = 1'b0;
    // hits only the invalid slot 2
    b.slots[3] = mkSlot(9, 1'b0, 4'h2, mkAddr(6, 0, 4'b1000, 32'h1));
    b.slots[4] = mkSlot(0, 1'b0, 4'h0, mkAddr(1, 0, 4'b1000, 32'h1));
    b.slots[5] = mkSlot(9, 1'b0, 4'h8, mkAddr(0, 8, 4'b0001, 32'h0001_0000));
    r = expectRetire(b);
    check("model enMask", 10'h209, r.enMask);
    check("model ldConfl", 10'h001, r.ldConfl);
    check("model fine", 10'h200, r.fine);
    sendBundle(b);
    repeat (6) sendBundle(randBundle());
    drainOutputs("mapping");
  endtask

  task automatic testThroughput();
    int firstSent;
    firstSent = 0;
    outReady = 1'b1;
    for (int n = 0; n < 40; n++) begin
      sendBundle(randBundle());
      if (n == 0) begin
        firstSent = lastSendCycle;
      end
    end
    drainOutputs("throughput");
    check("last word cycle", firstSent + 3 + 39, lastOutCycle);
  endtask

  task automatic testBackPressure();
    int accepted;
    accepted = 0;
    outReady = 1'b0;
    repeat (Depth + 3) begin
      if (inReady) begin
        sendBundle(randBundle());
        accepted++;
      end
    end
    // output register holds one beyond the buffer
    check("accepted under back-pressure", Depth + 1, accepted);
    repeat (3) @(negedge clk);
    check("inReady while stalled", 0, inReady);
    check("outValid while stalled", 1, outValid);
    outReady = 1'b1;
    drainOutputs("back-pressure");
  endtask

  task automatic testFlush();
    outReady = 1'b0;
    repeat (3) sendBundle(randBundle());
    repeat (2) @(negedge clk);
    // offered in the flush cycle, must be dropped
    inBundle = randBundle();
    inValid = 1'b1;
    flush = 1'b1;
    @(negedge clk);
    inValid = 1'b0;
    flush = 1'b0;
    expQ.delete();
    check("outValid after flush", 0, outValid);
    check("inReady after flush", 1, inReady);
    outReady = 1'b1;
    repeat (8) @(negedge clk);
    sendBundle(randBundle());
    drainOutputs("after flush");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      stopRun("cycle limit reached, the DUT stopped making progress");
    end else if (i_dut.i_props.failCount != 0) begin
      stopRun("a bound assertion on lsqTop failed");
    end
  end

  // output monitor
  always @(posedge clk) begin
    if (!rst && outValid && outReady) begin
      if (expQ.size() == 0) begin
        stopRun("retire word seen with no bundle outstanding");
      end else begin
        expWord = expQ.pop_front();
        compareWord(expWord, retire);
        lastOutCycle = cycles;
      end
    end
  end

  initial begin
    rst = 1'b1;
    flush = 1'b0;
    inValid = 1'b0;
    inBundle = '0;
    outReady = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("inReady after reset", 1, inReady);
    check("outValid after reset", 0, outValid);
    check("checkValid after reset", 0, i_dut.checkValid);
    check("headValid after reset", 0, i_dut.headValid);
    testLatencyConflict();
    testMapping();
    testThroughput();
    testBackPressure();
    testFlush();
    if (i_dut.i_props.failCount == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stopRun("a bound assertion on lsqTop failed");
    end
  end

endmodule

// File: sources.f
logic/lsqPkg.sv
logic/lsqConflictPair.sv
logic/lsqBundleCheck.sv
logic/lsqBundleBuffer.sv
logic/lsqRetireDecide.sv
logic/lsqTop.sv
sim/lsqTop_properties.sv
sim/lsqTb.sv

// File: Bender.yml
package:
  name: lsq

# order matters, the package comes first
sources:
  - logic/lsqPkg.sv
  - logic/lsqConflictPair.sv
  - logic/lsqBundleCheck.sv
  - logic/lsqBundleBuffer.sv
  - logic/lsqRetireDecide.sv
  - logic/lsqTop.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/lsqTop_properties.sv
      - sim/lsqTb.sv
